// File: verilog.f
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/stage_ifs.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - hw/rv_isa_pkg.sv
  - hw/pipe_pkg.sv
  - hw/stage_ifs.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/core_top.sv
  - target: test
    files:
      - tb/core_properties.sv
      - tb/core_tb.sv

// File: tb/core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module core_tb;

  logic        clk, arst_n, instr_valid, instr_ready;
  logic        retire_valid, retire_ready, retire_illegal, bp_on;
  logic [31:0] instr, retire_pc, retire_data, pc_next;
  logic [4:0]  retire_rd, last_rd;
  logic [31:0] stim_lfsr = 32'd77351;
  logic [31:0] bp_lfsr   = 32'd77351;
  logic [31:0] model_regs [32];
  logic [31:0] prog_q [$];
  logic [69:0] exp_q [$]; // {illegal, rd, pc, data}
  int          errors, tests_ok, tests_bad, prop_seen;
  string       test_name;

  core_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  // Mode 0 R-type, 1 I-type, 2 U-type, 3 RAW chain, 4 full mix, 5 x0 and illegal
  function automatic logic [31:0] gen_instr(input int mode);
    logic [2:0]  f3;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    logic [6:0]  op, f7;
    logic        alt;
    int          kind;
    f3   = 3'(rnd(3));
    rd   = 5'(rnd(3));
    rs1  = 5'(rnd(3));
    rs2  = 5'(rnd(3));
    imm  = 12'(rnd(12));
    alt  = rnd(1) != 0;
    op   = 7'(rnd(7));
    kind = (mode < 3) ? mode : (mode == 3) ? int'(rnd(1)) : int'(rnd(2));
    if (mode == 3) begin // Each instruction reads the previous result
      rs1 = last_rd;
      rd  = 5'(rnd(2)) + 5'd1;
    end
    if (mode == 5) begin
      rd  = rnd(1) ? 5'd0 : rd;
      rs1 = rnd(1) ? 5'd0 : rs1;
    end
    last_rd = rd;
    f7 = {1'b0, alt && (f3 == rv_isa_pkg::f3_add || f3 == rv_isa_pkg::f3_srl), 5'b0};
    if (f3 == rv_isa_pkg::f3_sll || f3 == rv_isa_pkg::f3_srl)
      imm = {f7, imm[4:0]};
    if (op inside {rv_isa_pkg::op_reg, rv_isa_pkg::op_imm,
                   rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc})
      op = 7'h7f;
    case (kind)
      0:       return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg};
      1:       return {imm, rs1, f3, rd, rv_isa_pkg::op_imm};
      2:       return {imm, rs2, f3, rd, alt ? rv_isa_pkg::op_lui : rv_isa_pkg::op_auipc};
      default: return {imm, rs1, f3, rd, op};
    endcase
  endfunction

  // Expected retire record from the architectural model
  function automatic logic [69:0] ref_retire(input logic [31:0] w, input logic [31:0] pc);
    logic [31:0] a, b, res;
    logic [6:0]  op;
    logic        legal;
    op    = w[6:0];
    a     = model_regs[w[19:15]];
    b     = (op == rv_isa_pkg::op_reg) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    legal = op inside {rv_isa_pkg::op_reg, rv_isa_pkg::op_imm,
                       rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc};
    res   = '0;
    if (op == rv_isa_pkg::op_lui)
      res = {w[31:12], 12'b0};
    else if (op == rv_isa_pkg::op_auipc)
      res = pc + {w[31:12], 12'b0};
    else if (legal) begin
      case (w[14:12])
        rv_isa_pkg::f3_add:  res = (op == rv_isa_pkg::op_reg && w[30]) ? a - b : a + b;
        rv_isa_pkg::f3_sll:  res = a << b[4:0];
        rv_isa_pkg::f3_slt:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
        rv_isa_pkg::f3_sltu: res = {31'b0, a < b};
        rv_isa_pkg::f3_xor:  res = a ^ b;
        rv_isa_pkg::f3_srl:  res = (a >> b[4:0]) |
                                   (~(32'hffff_ffff >> b[4:0]) & {32{w[30] & a[31]}});
        rv_isa_pkg::f3_or:   res = a | b;
        default:             res = a & b;
      endcase
    end
    return {!legal, w[11:7], pc, res};
  endfunction

  task automatic stream_program(input bit gaps);
    int guard;
    while (prog_q.size() > 0) begin
      if (gaps) begin
        instr_valid = 1'b0;
        repeat (rnd(2)) begin
          @(posedge clk);
          #1;
        end
      end
      instr_valid = 1'b1;
      instr       = prog_q.pop_front();
      guard       = 0;
      #1;
      while (!instr_ready && guard < 200) begin
        @(posedge clk);
        #2;
        guard++;
      end
      if (!instr_ready) begin
        $display("Timeout in %s: instr_ready stayed low for 200 cycles", test_name);
        errors++;
        prog_q.delete();
      end
      @(posedge clk);
      #1;
    end
    instr_valid = 1'b0;
  endtask

  task automatic run_test(input string name, input int mode, input int count, input bit gaps);
    logic [31:0] w;
    logic [69:0] rec;
    int          err0, guard;
    test_name = name;
    err0      = errors;
    for (int i = 0; i < count; i++) begin
      w   = gen_instr(mode);
      rec = ref_retire(w, pc_next);
      if (!rec[69] && rec[68:64] != 5'd0)
        model_regs[rec[68:64]] = rec[31:0];
      prog_q.push_back(w);
      exp_q.push_back(rec);
      pc_next += 32'd4;
    end
    stream_program(gaps);
    guard = 0;
    while (exp_q.size() > 0 && guard < 400) begin
      @(posedge clk);
      #1;
      guard++;
    end
    if (exp_q.size() > 0) begin
      $display("Timeout in %s: %0d instructions never retired", name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    // Bound assertion failures count against the test that saw them
    errors    += UUT.u_props.fail_cnt - prop_seen;
    prop_seen  = UUT.u_props.fail_cnt;
    if (errors == err0) begin
      tests_ok++;
      $display("test %-10s ok, %0d instructions", name, count);
    end else begin
      tests_bad++;
      $display("test %-10s %0d errors", name, errors - err0);
    end
  endtask

  // Back-pressure has its own LFSR stream, stepped once per cycle
  initial begin
    forever begin
      @(posedge clk);
      #1;
      bp_lfsr      = lfsr_step(bp_lfsr);
      retire_ready = bp_on ? bp_lfsr[0] : 1'b1;
    end
  end

  // Compare each retire handshake with the next expected record
  initial begin
    logic [69:0] e;
    forever begin
      @(posedge clk);
      #2;
      if (arst_n && retire_valid && retire_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("Retire at pc %h in %s with nothing outstanding", retire_pc, test_name);
          errors++;
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          assert ({retire_illegal, retire_rd, retire_pc, retire_data} == e) else begin
            $display("Fail %s pc/rd/data/illegal: expected %h %0d %h %b, actual %h %0d %h %b",
                     test_name, e[63:32], e[68:64], e[31:0], e[69],
                     retire_pc, retire_rd, retire_data, retire_illegal);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    arst_n       = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b0;
    bp_on        = 1'b0;
    last_rd      = 5'd1;
    pc_next      = '0;
    errors       = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    prop_seen    = 0;
    test_name    = "reset";
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    #1 arst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
    run_test("lui_auipc", 2, 24, 1'b0); // Also seeds the registers
    run_test("i_type", 1, 48, 1'b0);
    run_test("r_type", 0, 48, 1'b0);
    run_test("raw_chain", 3, 40, 1'b0);
    bp_on = 1'b1;
    run_test("stress", 4, 96, 1'b1);
    bp_on = 1'b0;
    run_test("x0_illegal", 5, 48, 1'b0);
    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/core_properties.sv
`default_nettype none
`timescale 1ns/1ps

module core_properties (
  input logic        clk,
  input logic        arst_n,
  input logic        instr_valid,
  input logic        instr_ready,
  input logic        retire_valid,
  input logic        retire_ready,
  input logic [31:0] retire_pc,
  input logic [4:0]  retire_rd,
  input logic [31:0] retire_data,
  input logic        retire_illegal
);

  int inflight; // Accepted but not yet retired
  int fail_cnt = 0; // Assertion failures so far

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) inflight <= 0;
    else inflight <= inflight + int'(instr_valid && instr_ready)
                              - int'(retire_valid && retire_ready);
  end

  retire_hold: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid && !retire_ready |=> retire_valid &&
      $stable({retire_pc, retire_rd, retire_data, retire_illegal}))
    else begin
      $error("retire dropped or changed before retire_ready");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge clk) !arst_n |-> !retire_valid && !instr_ready)
    else begin
      $error("handshake active during reset");
      fail_cnt++;
    end

  // Empty pipe means no hazard and nothing to back-pressure
  empty_latency: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid && instr_ready && inflight == 0 |-> ##[1:3] retire_valid)
    else begin
      $error("retire later than 3 cycles through an empty pipe");
      fail_cnt++;
    end

endmodule

bind core_top core_properties u_props (.*);

`default_nettype wire

// File: hw/core_top.sv
`default_nettype none
`timescale 1ns/1ps

module core_top (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           instr_valid,
  output logic                           instr_ready,
  input  logic [rv_isa_pkg::xlen-1:0]    instr,
  output logic                           retire_valid,
  input  logic                           retire_ready,
  output logic [rv_isa_pkg::xlen-1:0]    retire_pc,
  output logic [pipe_pkg::reg_idx_w-1:0] retire_rd,
  output logic [rv_isa_pkg::xlen-1:0]    retire_data,
  output logic                           retire_illegal
);

  if_to_id_if f2d ();
  id_to_ex_if d2e ();
  wb_if       wb  ();

  fetch_stage u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .out         (f2d)
  );

  decode_stage u_decode (
    .clk    (clk),
    .arst_n (arst_n),
    .in     (f2d),
    .out    (d2e),
    .wb     (wb)
  );

  execute_stage u_execute (
    .clk            (clk),
    .arst_n         (arst_n),
    .in             (d2e),
    .wb             (wb),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal)
  );

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
  input  logic                           clk,
  input  logic                           arst_n,
  id_to_ex_if.dst                        in,
  wb_if.src                              wb,
  output logic                           retire_valid,
  input  logic                           retire_ready,
  output logic [rv_isa_pkg::xlen-1:0]    retire_pc,
  output logic [pipe_pkg::reg_idx_w-1:0] retire_rd,
  output logic [rv_isa_pkg::xlen-1:0]    retire_data,
  output logic                           retire_illegal
);

  logic [rv_isa_pkg::xlen-1:0] opnd_a, alu_res;
  logic [4:0]                  shamt;
  logic                        take;

  assign opnd_a = (in.src_a == pipe_pkg::src_a_pc) ? in.pc : in.opnd_a_reg;
  assign shamt  = in.opnd_b[4:0];

  always_comb begin
    case (in.alu_op)
      pipe_pkg::alu_add:    alu_res = opnd_a + in.opnd_b;
      pipe_pkg::alu_sub:    alu_res = opnd_a - in.opnd_b;
      pipe_pkg::alu_sll:    alu_res = opnd_a << shamt;
      pipe_pkg::alu_slt:    alu_res = {31'b0, $signed(opnd_a) < $signed(in.opnd_b)};
      pipe_pkg::alu_sltu:   alu_res = {31'b0, opnd_a < in.opnd_b};
      pipe_pkg::alu_xor:    alu_res = opnd_a ^ in.opnd_b;
      pipe_pkg::alu_srl:    alu_res = opnd_a >> shamt;
      pipe_pkg::alu_sra:    alu_res = $signed(opnd_a) >>> shamt;
      pipe_pkg::alu_or:     alu_res = opnd_a | in.opnd_b;
      pipe_pkg::alu_and:    alu_res = opnd_a & in.opnd_b;
      pipe_pkg::alu_pass_b: alu_res = in.opnd_b;
      default:              alu_res = '0;
    endcase
  end

  assign in.ready = !retire_valid || retire_ready;
  assign take     = in.valid && in.ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) retire_valid <= 1'b0;
    else if (take) retire_valid <= 1'b1;
    else if (retire_ready) retire_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (take) begin
      retire_pc      <= in.pc;
      retire_rd      <= in.rd;
      retire_data    <= in.illegal ? '0 : alu_res;
      retire_illegal <= in.illegal;
    end
  end

  // Register file write lands on the retire edge
  assign wb.we   = retire_valid && retire_ready && !retire_illegal && (retire_rd != '0);
  assign wb.rd   = retire_rd;
  assign wb.data = retire_data;

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
  input  logic    clk,
  input  logic    arst_n,
  if_to_id_if.dst in,
  id_to_ex_if.src out,
  wb_if.dst       wb
);

  rv_isa_pkg::instr_t             ir;
  logic [rv_isa_pkg::xlen-1:0]    regs [1:31];
  logic [31:0]                    pending; // Bit per register with a write in flight
  logic [rv_isa_pkg::xlen-1:0]    rs1_data, rs2_data, opnd_b;
  pipe_pkg::alu_op_t              alu_op;
  pipe_pkg::src_a_t               src_a;
  logic                           use_rs1, use_rs2, illegal, alt;
  logic                           writes_rd, hazard, issue;

  assign ir  = in.instr;
  assign alt = ir.r_fmt.funct7[5]; // SUB and SRA/SRAI

  assign rs1_data = (ir.r_fmt.rs1 == '0) ? '0 : regs[ir.r_fmt.rs1];
  assign rs2_data = (ir.r_fmt.rs2 == '0) ? '0 : regs[ir.r_fmt.rs2];

  always_comb begin
    alu_op  = pipe_pkg::alu_add;
    src_a   = pipe_pkg::src_a_rs1;
    opnd_b  = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    illegal = 1'b0;
    case (ir.r_fmt.opcode)
      rv_isa_pkg::op_reg, rv_isa_pkg::op_imm: begin
        use_rs1 = 1'b1;
        use_rs2 = (ir.r_fmt.opcode == rv_isa_pkg::op_reg);
        opnd_b  = use_rs2 ? rs2_data : {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
        case (ir.r_fmt.funct3)
          rv_isa_pkg::f3_add:  alu_op = (use_rs2 && alt) ? pipe_pkg::alu_sub : pipe_pkg::alu_add;
          rv_isa_pkg::f3_sll:  alu_op = pipe_pkg::alu_sll;
          rv_isa_pkg::f3_slt:  alu_op = pipe_pkg::alu_slt;
          rv_isa_pkg::f3_sltu: alu_op = pipe_pkg::alu_sltu;
          rv_isa_pkg::f3_xor:  alu_op = pipe_pkg::alu_xor;
          rv_isa_pkg::f3_srl:  alu_op = alt ? pipe_pkg::alu_sra : pipe_pkg::alu_srl;
          rv_isa_pkg::f3_or:   alu_op = pipe_pkg::alu_or;
          default:             alu_op = pipe_pkg::alu_and;
        endcase
      end
      rv_isa_pkg::op_lui: begin
        alu_op = pipe_pkg::alu_pass_b;
        opnd_b = {ir.u_fmt.imm, 12'b0};
      end
      rv_isa_pkg::op_auipc: begin
        src_a  = pipe_pkg::src_a_pc;
        opnd_b = {ir.u_fmt.imm, 12'b0};
      end
      default: illegal = 1'b1;
    endcase
  end

  // Wait on pending sources, and on a pending rd so writes retire in order
  assign writes_rd = !illegal && (ir.r_fmt.rd != '0);
  assign hazard    = in.valid && ((use_rs1 && pending[ir.r_fmt.rs1]) ||
                                  (use_rs2 && pending[ir.r_fmt.rs2]) ||
                                  (writes_rd && pending[ir.r_fmt.rd]));
  assign in.ready  = (!out.valid || out.ready) && !hazard;
  assign issue     = in.valid && in.ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out.valid <= 1'b0;
      pending   <= '0;
    end else begin
      if (issue) out.valid <= 1'b1;
      else if (out.ready) out.valid <= 1'b0;
      if (wb.we) pending[wb.rd] <= 1'b0;
      if (issue && writes_rd) pending[ir.r_fmt.rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      out.alu_op     <= alu_op;
      out.src_a      <= src_a;
      out.opnd_a_reg <= rs1_data;
      out.opnd_b     <= opnd_b;
      out.pc         <= in.pc;
      out.rd         <= ir.r_fmt.rd;
      out.illegal    <= illegal;
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  output logic               instr_ready,
  input  rv_isa_pkg::instr_t instr,
  if_to_id_if.src            out
);

  logic [rv_isa_pkg::xlen-1:0] pc_cnt;
  logic                        run; // Held off until the first edge after reset
  logic                        take;

  assign instr_ready = run && (!out.valid || out.ready);
  assign take        = instr_valid && instr_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run       <= 1'b0;
      out.valid <= 1'b0;
      pc_cnt    <= '0;
    end else begin
      run <= 1'b1;
      if (take) begin
        out.valid <= 1'b1;
        pc_cnt    <= pc_cnt + 32'd4;
      end else if (out.ready) begin
        out.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out.instr <= instr;
      out.pc    <= pc_cnt;
    end
  end

endmodule

`default_nettype wire

// File: hw/stage_ifs.sv
`default_nettype none
`timescale 1ns/1ps

// Fetch to decode
interface if_to_id_if;
  logic                          valid;
  logic                          ready;
  rv_isa_pkg::instr_t            instr;
  logic [rv_isa_pkg::xlen-1:0]   pc;

  modport src (output valid, instr, pc, input ready);
  modport dst (input valid, instr, pc, output ready);
endinterface

// Decode to execute
interface id_to_ex_if;
  logic                          valid;
  logic                          ready;
  pipe_pkg::alu_op_t             alu_op;
  pipe_pkg::src_a_t              src_a;
  logic [rv_isa_pkg::xlen-1:0]   opnd_a_reg;
  logic [rv_isa_pkg::xlen-1:0]   opnd_b; // rs2 value or immediate
  logic [rv_isa_pkg::xlen-1:0]   pc;
  logic [pipe_pkg::reg_idx_w-1:0] rd;
  logic                          illegal;

  modport src (
    output valid, alu_op, src_a, opnd_a_reg, opnd_b, pc, rd, illegal,
    input  ready
  );
  modport dst (
    input  valid, alu_op, src_a, opnd_a_reg, opnd_b, pc, rd, illegal,
    output ready
  );
endinterface

// Register file write port, one pulse per retired write
interface wb_if;
  logic                           we;
  logic [pipe_pkg::reg_idx_w-1:0] rd;
  logic [rv_isa_pkg::xlen-1:0]    data;

  modport src (output we, rd, data);
  modport dst (input we, rd, data);
endinterface

`default_nettype wire

// File: hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int unsigned reg_idx_w = 5;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // LUI places the upper immediate as is
  } alu_op_t;

  // A operand source, pc only for AUIPC
  typedef enum logic {
    src_a_rs1,
    src_a_pc
  } src_a_t;

endpackage

`default_nettype wire

// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int unsigned xlen = 32;

  // Major opcodes of the supported subset
  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;

  localparam logic [2:0] f3_add  = 3'b000; // Also ADDI and SUB
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101; // Also SRA, told apart by funct7
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One instruction word, viewed in whichever format the opcode calls for
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } instr_t;

endpackage

`default_nettype wire
